// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pad_if_tb
FILELIST  ?= pad_if_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/pad_bus_decode.sv ====
// AXI4-Lite slave front end of the pad interface
// accepts single transfers and turns addresses into register selects
`timescale 1ns/1ps
`include "pad_settings.svh"

module pad_bus_decode
    import pad_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    // write address and data, taken together
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`PAD_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    // write response
    output logic                   bvalid,
    input  logic                   bready,
    output axi_resp_t              bresp,
    // read address and data
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`PAD_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output axi_resp_t              rresp,
    // register block side
    output logic                   wr_en,
    output reg_sel_t               wr_sel,
    output logic [31:0]            wr_data,
    output logic                   rd_en,
    output reg_sel_t               rd_sel,
    input  logic [31:0]            rd_data
);

    logic wr_accept;
    logic rd_accept;

    // word offsets of the map, anything else including unaligned
    // offsets falls to SEL_NONE
    function automatic reg_sel_t addr_to_sel(input logic [`PAD_ADDR_W-1:0] addr);
        case (addr)
            `PAD_REG_CTRL: return SEL_CTRL;
            `PAD_REG_P0:   return SEL_P0;
            `PAD_REG_P1:   return SEL_P1;
            `PAD_REG_EVT:  return SEL_EVT;
            default:       return SEL_NONE;
        endcase
    endfunction

    // ========================================
    // write channel
    // ========================================

    // address and data are taken in the same cycle, and only while
    // no response is waiting for bready
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign wr_en   = wr_accept;
    assign wr_sel  = addr_to_sel(awaddr);
    assign wr_data = wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= OKAY;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
            // only CTRL is writable, the status registers refuse writes
            bresp  <= (wr_sel == SEL_CTRL) ? OKAY : SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // ========================================
    // read channel
    // ========================================

    assign arready   = !rvalid;
    assign rd_accept = arvalid && !rvalid;
    assign rd_en     = rd_accept;
    assign rd_sel    = addr_to_sel(araddr);

    // the register block updates rd_data only on rd_en, which cannot
    // happen while rvalid is up, so it can feed rdata straight through
    assign rdata = rd_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            rresp  <= OKAY;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
            rresp  <= (rd_sel == SEL_NONE) ? SLVERR : OKAY;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // a pending read response must not change before the master takes it
    read_data_stable: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

// ==== hdl/pad_bus_pkg.sv ====
// AXI4-Lite response codes and the register select used between
// the bus front end and the register block
package pad_bus_pkg;

    // only the two responses this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // decoded register target of one transfer
    // SEL_NONE marks an offset outside the map
    typedef enum logic [2:0] {
        SEL_CTRL = 3'd0,
        SEL_P0   = 3'd1,
        SEL_P1   = 3'd2,
        SEL_EVT  = 3'd3,
        SEL_NONE = 3'd4
    } reg_sel_t;

endpackage

// ==== hdl/pad_if_top.sv ====
// top level of the pad interface
// AXI4-Lite front end, pad scanner and register block
`timescale 1ns/1ps
`include "pad_settings.svh"

module pad_if_top
    import pad_types_pkg::*, pad_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`PAD_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    output logic                   wready,
    input  logic [31:0]            wdata,
    output logic                   bvalid,
    input  logic                   bready,
    output axi_resp_t              bresp,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`PAD_ADDR_W-1:0] araddr,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output axi_resp_t              rresp,
    // DB9 pad port, lines active low
    output logic                   split,
    output logic                   mdsel,
    input  logic [5:0]             din
);

    logic         wr_en;
    reg_sel_t     wr_sel;
    logic [31:0]  wr_data;
    logic         rd_en;
    reg_sel_t     rd_sel;
    logic [31:0]  rd_data;
    logic         scan_en;
    pad_buttons_t joy0;
    pad_buttons_t joy1;
    logic         sample;

    pad_bus_decode u_pad_bus_decode (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

    pad_scanner u_pad_scanner (
        .clk     (clk),
        .rst     (rst),
        .scan_en (scan_en),
        .din     (din),
        .split   (split),
        .mdsel   (mdsel),
        .joy0    (joy0),
        .joy1    (joy1),
        .sample  (sample)
    );

    pad_result_regs u_pad_result_regs (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_sel  (rd_sel),
        .joy0    (joy0),
        .joy1    (joy1),
        .sample  (sample),
        .scan_en (scan_en),
        .rd_data (rd_data)
    );

endmodule

// ==== hdl/pad_result_regs.sv ====
// control, player state and press event registers of the pad interface
// and the registered read data path
`timescale 1ns/1ps

module pad_result_regs
    import pad_types_pkg::*, pad_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         wr_en,
    input  reg_sel_t     wr_sel,
    input  logic [31:0]  wr_data,
    input  logic         rd_en,
    input  reg_sel_t     rd_sel,
    input  pad_buttons_t joy0,
    input  pad_buttons_t joy1,
    input  logic         sample,
    output logic         scan_en,
    output logic [31:0]  rd_data
);

    pad_buttons_t p0_q;
    pad_buttons_t p1_q;
    logic [31:0]  evt;
    logic [31:0]  evt_rise;

    // buttons that went from released to pressed since the last sample
    // player 0 in the low half, player 1 from bit 16
    assign evt_rise = sample ? {4'b0, joy1 & ~p1_q, 4'b0, joy0 & ~p0_q} : 32'b0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_en <= 1'b0;
            p0_q    <= '0;
            p1_q    <= '0;
            evt     <= '0;
        end else begin
            // CTRL bit 0 enables scanning, the other bits are not stored
            if (wr_en && wr_sel == SEL_CTRL) begin
                scan_en <= wr_data[0];
            end
            // both player words are complete when sample pulses
            if (sample) begin
                p0_q <= joy0;
                p1_q <= joy1;
            end
            // reading EVT clears it, but a press in that cycle survives
            if (rd_en && rd_sel == SEL_EVT) begin
                evt <= evt_rise;
            end else begin
                evt <= evt | evt_rise;
            end
        end
    end

    // read data is latched at address acceptance and held for the response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            case (rd_sel)
                SEL_CTRL: rd_data <= {31'b0, scan_en};
                SEL_P0:   rd_data <= {20'b0, p0_q};
                SEL_P1:   rd_data <= {20'b0, p1_q};
                SEL_EVT:  rd_data <= evt;
                default:  rd_data <= '0;
            endcase
        end
    end

endmodule

// ==== hdl/pad_scanner.sv ====
// Mega Drive pad scanner for two players on one DB9 connector
// drives split and mdsel, samples the lines and builds the 12-button words
`timescale 1ns/1ps
`include "pad_settings.svh"

module pad_scanner
    import pad_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         scan_en,
    input  logic [5:0]   din,
    output logic         split,
    output logic         mdsel,
    output pad_buttons_t joy0,
    output pad_buttons_t joy1,
    output logic         sample
);

    localparam int DIV   = `PAD_CEN_DIV;
    localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    // bit 3 picks the player, bit 0 picks the half of the button word
    logic [3:0]       phase;
    logic             last_split;
    logic             md6;
    pad_buttons_t     joy_scan;
    pad_lines_u       lines;

    // the pad lines are active low
    assign lines.raw = ~din;

    // both selects idle high while scanning is off
    assign split = scan_en ? phase[3] : 1'b1;
    assign mdsel = scan_en ? phase[0] : 1'b1;

    // one tick per select phase, at the end of the phase so the pad
    // has had the whole phase to settle
    assign tick = scan_en && (div_cnt == DIV_W'(DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt    <= '0;
            phase      <= 4'd0;
            last_split <= 1'b0;
            md6        <= 1'b0;
            joy_scan   <= '0;
            joy0       <= '0;
            joy1       <= '0;
            sample     <= 1'b0;
        end else if (!scan_en) begin
            // restart from player 1, low mdsel; last_split matches the
            // first split level so enabling does not fake an edge
            div_cnt    <= '0;
            phase      <= 4'd0;
            last_split <= 1'b0;
            md6        <= 1'b0;
            joy_scan   <= '0;
            sample     <= 1'b0;
        end else begin
            last_split <= split;
            sample     <= 1'b0;
            div_cnt    <= tick ? '0 : div_cnt + 1'b1;

            // ========================================
            // player hand-over at each split edge
            // ========================================
            if (split != last_split) begin
                joy_scan <= '0;
                md6      <= 1'b0;
                if (split) begin
                    // the low split half belongs to player 1
                    joy1 <= joy_scan;
                end else begin
                    joy0   <= joy_scan;
                    sample <= 1'b1;
                end
            end

            // ========================================
            // line capture once per select phase
            // ========================================
            if (tick) begin
                phase <= phase + 4'd1;
                if (!mdsel) begin
                    // a pad pulls lines 3:2 low in every low phase, and a
                    // 6-button pad also pulls 1:0 low on its handshake phase
                    md6 <= (din[1:0] == 2'b00) && (din[3:2] == 2'b00);
                    if (din[3:2] == 2'b00) begin
                        joy_scan[BTN_A]     <= lines.raw[4];
                        joy_scan[BTN_START] <= lines.raw[5];
                    end
                end else if (md6) begin
                    // phase right after the handshake carries the extra buttons
                    joy_scan[BTN_Z]    <= lines.ext.z;
                    joy_scan[BTN_Y]    <= lines.ext.y;
                    joy_scan[BTN_X]    <= lines.ext.x;
                    joy_scan[BTN_MODE] <= lines.ext.mode;
                end else begin
                    joy_scan[BTN_UP]    <= lines.raw[0];
                    joy_scan[BTN_DOWN]  <= lines.raw[1];
                    joy_scan[BTN_LEFT]  <= lines.raw[2];
                    joy_scan[BTN_RIGHT] <= lines.raw[3];
                    joy_scan[BTN_B]     <= lines.raw[4];
                    joy_scan[BTN_C]     <= lines.raw[5];
                end
            end
        end
    end

    // enabling the scan leaves the idle port for player 1 in a low mdsel
    // phase with a fresh tick divider, so the pad sees a whole handshake
    scan_restart: assert property (
        @(posedge clk) disable iff (rst)
        $rose(scan_en) |-> !split && !mdsel && div_cnt == '0
    );

endmodule

// ==== hdl/pad_settings.svh ====
// scan tick divider, AXI address width and register byte offsets
// shared by the bus front end and the scanner
`ifndef PAD_SETTINGS_SVH
`define PAD_SETTINGS_SVH

// clk cycles per scan tick, one tick per pad select phase
`define PAD_CEN_DIV 8

// AXI4-Lite address width, enough for four word registers
`define PAD_ADDR_W 4

// register map, byte offsets
`define PAD_REG_CTRL 4'h0
`define PAD_REG_P0   4'h4
`define PAD_REG_P1   4'h8
`define PAD_REG_EVT  4'hC

`endif

// ==== hdl/pad_types_pkg.sv ====
// button word layout of one player and the two views of the raw pad lines
package pad_types_pkg;

    // 12-bit active-high button state of one player
    typedef logic [11:0] pad_buttons_t;

    // bit positions inside pad_buttons_t
    localparam int BTN_UP    = 0;
    localparam int BTN_DOWN  = 1;
    localparam int BTN_LEFT  = 2;
    localparam int BTN_RIGHT = 3;
    localparam int BTN_B     = 4;
    localparam int BTN_C     = 5;
    localparam int BTN_A     = 6;
    localparam int BTN_START = 7;
    localparam int BTN_Z     = 8;
    localparam int BTN_Y     = 9;
    localparam int BTN_X     = 10;
    localparam int BTN_MODE  = 11;

    // the six pad lines after inversion, so a pressed button reads 1
    // in the normal phases the raw view carries up/down/left/right/B/C,
    // after the 6-button handshake the same lines carry Z/Y/X/Mode
    typedef union packed {
        logic [5:0] raw;
        struct packed {
            logic [1:0] unused;
            logic       mode;
            logic       x;
            logic       y;
            logic       z;
        } ext;
    } pad_lines_u;

endpackage

// ==== pad_if_top.f ====
+incdir+hdl
hdl/pad_types_pkg.sv
hdl/pad_bus_pkg.sv
hdl/pad_bus_decode.sv
hdl/pad_scanner.sv
hdl/pad_result_regs.sv
hdl/pad_if_top.sv
test/pad_model.sv
test/pad_if_tb.sv

// ==== test/pad_if_tb.sv ====
// pad interface testbench reading its tests from the stim file rows
// AXI4-Lite access tasks, typed compare tasks and a cycle-count timeout
`timescale 1ns/1ps
`include "pad_settings.svh"

module pad_if_tb
    import pad_types_pkg::*, pad_bus_pkg::*;
;

    localparam int MAX_ROWS = 32;
    // two full frames plus some slack for the register pipeline
    localparam int SETTLE   = 32 * `PAD_CEN_DIV + 32;

    logic                   clk;
    logic                   rst;
    logic                   awvalid;
    logic                   awready;
    logic [`PAD_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [31:0]            wdata;
    logic                   bvalid;
    logic                   bready;
    axi_resp_t              bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`PAD_ADDR_W-1:0] araddr;
    logic                   rvalid;
    logic                   rready;
    logic [31:0]            rdata;
    axi_resp_t              rresp;
    logic                   split;
    logic                   mdsel;
    logic [5:0]             din;

    logic                   six_btn0;
    logic                   six_btn1;
    pad_buttons_t           buttons0;
    pad_buttons_t           buttons1;

    // one entry per stim row
    logic [8*20-1:0]        row_name [0:MAX_ROWS-1];
    logic [31:0]            row_six0 [0:MAX_ROWS-1];
    logic [31:0]            row_six1 [0:MAX_ROWS-1];
    logic [31:0]            row_pad0 [0:MAX_ROWS-1];
    logic [31:0]            row_pad1 [0:MAX_ROWS-1];
    logic [31:0]            row_p0   [0:MAX_ROWS-1];
    logic [31:0]            row_p1   [0:MAX_ROWS-1];
    logic [31:0]            row_evt  [0:MAX_ROWS-1];
    int                     rows;
    int                     cycles;
    int                     limit;

    pad_if_top u_pad_if_top (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .split   (split),
        .mdsel   (mdsel),
        .din     (din)
    );

    pad_model u_pad_model (
        .split    (split),
        .mdsel    (mdsel),
        .six_btn0 (six_btn0),
        .six_btn1 (six_btn1),
        .buttons0 (buttons0),
        .buttons1 (buttons1),
        .din      (din)
    );

    always #20 clk = ~clk;

    // ========================================
    // failure reporting and compares
    // ========================================

    task automatic report_failure();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_buttons(input logic [8*20-1:0] name, input pad_buttons_t exp,
                                 input pad_buttons_t act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_resp(input logic [8*20-1:0] name, input axi_resp_t exp,
                              input axi_resp_t act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    // full 32-bit register words, used for EVT and CTRL
    task automatic check_word(input logic [8*20-1:0] name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %0s: expected %h, actual %h", name, exp, act);
            report_failure();
        end
    endtask

    // ========================================
    // AXI4-Lite master tasks
    // ========================================

    task automatic write_reg(input logic [`PAD_ADDR_W-1:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        bready  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    // hold keeps rready low for that many cycles after rvalid rises
    task automatic read_reg(input logic [`PAD_ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] data, output axi_resp_t resp);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        rready  <= 1'b0;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (!rvalid || rdata !== data || rresp !== resp) begin
                $display("read response changed while rready was held low");
                report_failure();
            end
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // new pad settings go in right after a player hand-over so that
    // no half frame is scanned with two different pad kinds
    task automatic wait_split_edge();
        logic start;
        @(negedge clk);
        start = split;
        do @(negedge clk); while (split === start);
    endtask

    // ========================================
    // stim file and timeout
    // ========================================

    task automatic load_stim();
        int              fd;
        int              n;
        int              got;
        logic [8*128-1:0] line;
        logic [8*20-1:0] tname;
        logic [31:0]     f0, f1, f2, f3, f4, f5, f6;
        fd = $fopen("test/pad_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stim file test/pad_stim.txt");
            report_failure();
        end
        rows = 0;
        while (!$feof(fd)) begin
            line = '0;
            n    = 0;
            got  = $fgets(line, fd);
            if (got > 0) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                            tname, f0, f1, f2, f3, f4, f5, f6);
            end
            // comment lines stop after the first token
            if (n == 8 && rows < MAX_ROWS) begin
                row_name[rows] = tname;
                row_six0[rows] = f0;
                row_six1[rows] = f1;
                row_pad0[rows] = f2;
                row_pad1[rows] = f3;
                row_p0[rows]   = f4;
                row_p1[rows]   = f5;
                row_evt[rows]  = f6;
                rows++;
            end else if (n > 1) begin
                $display("malformed line in the stim file");
                report_failure();
            end
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles", cycles);
            report_failure();
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin
        logic [31:0] data;
        axi_resp_t   resp;
        clk      = 1'b0;
        rst      = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        six_btn0 = 1'b0;
        six_btn1 = 1'b0;
        buttons0 = '0;
        buttons1 = '0;
        cycles   = 0;
        limit    = 0;

        load_stim();
        if (rows == 0) begin
            $display("the stim file holds no test rows");
            report_failure();
        end
        limit = rows * (40 * `PAD_CEN_DIV + 64);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // registers are clear and the pad port idles after reset
        read_reg(`PAD_REG_P0, 0, data, resp);
        check_buttons("reset_p0", '0, data[11:0]);
        read_reg(`PAD_REG_P1, 0, data, resp);
        check_buttons("reset_p1", '0, data[11:0]);
        read_reg(`PAD_REG_EVT, 0, data, resp);
        check_word("reset_evt", 32'h0, data);
        repeat (4 * `PAD_CEN_DIV) begin
            @(negedge clk);
            if (!(split && mdsel)) begin
                $display("pad selects left idle before scanning was enabled");
                report_failure();
            end
        end
        write_reg(`PAD_REG_CTRL, 32'h1, resp);
        check_resp("ctrl_enable", OKAY, resp);

        for (int r = 0; r < rows; r++) begin
            wait_split_edge();
            @(posedge clk);
            six_btn0 <= row_six0[r][0];
            six_btn1 <= row_six1[r][0];
            buttons0 <= row_pad0[r][11:0];
            buttons1 <= row_pad1[r][11:0];
            repeat (SETTLE) @(posedge clk);
            read_reg(`PAD_REG_P0, 0, data, resp);
            check_buttons(row_name[r], row_p0[r][11:0], data[11:0]);
            check_word(row_name[r], {20'b0, row_p0[r][11:0]}, data);
            read_reg(`PAD_REG_P1, 0, data, resp);
            check_buttons(row_name[r], row_p1[r][11:0], data[11:0]);
            read_reg(`PAD_REG_EVT, 0, data, resp);
            check_word(row_name[r], row_evt[r], data);
            // the first read cleared the events
            read_reg(`PAD_REG_EVT, 0, data, resp);
            check_word(row_name[r], 32'h0, data);
        end

        // a stalled read response keeps its data until accepted
        read_reg(`PAD_REG_P0, 6, data, resp);
        check_buttons("stalled_read", row_p0[rows-1][11:0], data[11:0]);
        check_resp("stalled_read", OKAY, resp);

        // read-only and unmapped offsets refuse access
        write_reg(`PAD_REG_P0, 32'hfff, resp);
        check_resp("write_p0", SLVERR, resp);
        write_reg(`PAD_REG_P1, 32'hfff, resp);
        check_resp("write_p1", SLVERR, resp);
        write_reg(`PAD_REG_EVT, 32'hfff, resp);
        check_resp("write_evt", SLVERR, resp);
        write_reg(4'h6, 32'h1, resp);
        check_resp("write_unmapped", SLVERR, resp);
        read_reg(4'h6, 0, data, resp);
        check_resp("read_unmapped", SLVERR, resp);
        read_reg(4'h1, 0, data, resp);
        check_resp("read_unaligned", SLVERR, resp);
        write_reg(`PAD_REG_CTRL, 32'h1, resp);
        check_resp("ctrl_rewrite", OKAY, resp);
        read_reg(`PAD_REG_CTRL, 0, data, resp);
        check_word("ctrl_read", 32'h1, data);

        $display("test passed");
        $finish;
    end

endmodule

// ==== test/pad_model.sv ====
// behavioral model of two Mega Drive pads sharing one DB9 connector
// answers split and mdsel as a 3-button or 6-button pad per player
`timescale 1ns/1ps

module pad_model
    import pad_types_pkg::*;
(
    input  logic         split,
    input  logic         mdsel,
    input  logic         six_btn0,
    input  logic         six_btn1,
    input  pad_buttons_t buttons0,
    input  pad_buttons_t buttons1,
    output logic [5:0]   din
);

    logic         prev_split = 1'b1;
    logic         prev_mdsel = 1'b1;
    int           low_cnt    = 0;
    pad_buttons_t sel_btn;
    logic         six;

    // count low mdsel phases since the last player hand-over
    always @(split or mdsel) begin
        if (split !== prev_split) begin
            // a hand-over starts in a low mdsel phase, which is the first one
            low_cnt = mdsel ? 0 : 1;
        end else if (prev_mdsel && !mdsel) begin
            low_cnt = low_cnt + 1;
        end
        prev_split = split;
        prev_mdsel = mdsel;
    end

    // split high selects player 0, low selects player 1
    // all lines are active low
    always_comb begin
        sel_btn = split ? buttons0 : buttons1;
        six     = split ? six_btn0 : six_btn1;
        if (!mdsel) begin
            if (six && low_cnt == 3) begin
                // 6-button handshake pulls lines 3:0 low together
                din = {~sel_btn[BTN_START], ~sel_btn[BTN_A], 4'b0000};
            end else begin
                din = {~sel_btn[BTN_START], ~sel_btn[BTN_A], 2'b00,
                       ~sel_btn[BTN_DOWN], ~sel_btn[BTN_UP]};
            end
        end else if (six && low_cnt == 3) begin
            din = {2'b11, ~sel_btn[BTN_MODE], ~sel_btn[BTN_X],
                   ~sel_btn[BTN_Y], ~sel_btn[BTN_Z]};
        end else begin
            din = {~sel_btn[BTN_C], ~sel_btn[BTN_B], ~sel_btn[BTN_RIGHT],
                   ~sel_btn[BTN_LEFT], ~sel_btn[BTN_DOWN], ~sel_btn[BTN_UP]};
        end
    end

endmodule

// ==== test/pad_stim.txt ====
# test_name six_btn0 six_btn1 pad0 pad1 exp_p0 exp_p1 exp_evt
# hex values, buttons from bit 0 up are up down left right B C A Start Z Y X Mode
three_basic 0 0 0F1 F0A 0F1 00A 000A00F1
three_dir   0 0 90C 054 00C 054 0054000C
six_p0      1 0 F42 300 F42 000 00000F42
six_p1      0 1 A81 5A2 081 5A2 05A20081
six_both    1 1 C29 3D4 C29 3D4 02540C28
release     1 1 000 000 000 000 00000000
repress     0 0 0F5 0AA 0F5 0AA 00AA00F5
